// File: Makefile
# Verilator build for the load queue testbench

VERILATOR ?= verilator
TOP       ?= ldq_tb
FILELIST  ?= ldq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) hw/*.sv hw/*.svh test/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/ldq_cfg.svh
`ifndef LDQ_CFG_SVH
`define LDQ_CFG_SVH

// Queue depth and dispatch width
`define LDQ_SIZE     8
`define LDQ_DISP_W   2

// Load pipes, also the number of store hazard-check ports
`define LDQ_PIPES    2

`define LDQ_TAG_W    5
`define LDQ_PADDR_W  32

// Wide enough to hold a count of 0..LDQ_SIZE
`define LDQ_CNT_W    4

`endif

// File: hw/ldq_entry.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_entry (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,
  input  wire ldq_pkg::alloc_t   i_alloc,
  input  wire ldq_pkg::ldq_upd_t i_upd [`LDQ_PIPES],
  input  wire ldq_pkg::commit_t  i_commit,
  input  wire logic              i_flush,
  input  wire logic              i_is_oldest,
  output ldq_pkg::ldq_entry_t    o_entry,
  output logic                   o_finish
);

  logic                    r_valid;
  logic                    r_has_data;
  logic                    r_committed;
  ldq_pkg::tag_t           r_tag;
  logic [`LDQ_PADDR_W-1:0] r_paddr;
  ldq_pkg::ld_size_t       r_size;

  logic [`LDQ_PIPES-1:0]   w_upd_hit;
  logic                    w_upd_valid;
  logic [`LDQ_PADDR_W-1:0] w_upd_paddr;
  ldq_pkg::ld_size_t       w_upd_size;
  logic                    w_commit_hit;

  // ----------------------------------------------------------------------
  // EX2 update match across load pipes
  // ----------------------------------------------------------------------
  // At most one pipe carries a given tag in a cycle
  always_comb begin : upd_sel_blk
    w_upd_paddr = '0;
    w_upd_size  = '0;
    for (int p = 0; p < `LDQ_PIPES; p++) begin
      w_upd_hit[p] = r_valid && i_upd[p].valid && (i_upd[p].tag == r_tag);
      if (w_upd_hit[p]) begin
        w_upd_paddr = i_upd[p].paddr;
        w_upd_size  = i_upd[p].size;
      end
    end
  end

  assign w_upd_valid  = |w_upd_hit;
  assign w_commit_hit = r_valid && i_commit.valid && (i_commit.tag == r_tag);

  // Leaves the queue only from the head
  assign o_finish = r_valid && r_committed && r_has_data && i_is_oldest;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= 1'b0;
      r_has_data  <= 1'b0;
      r_committed <= 1'b0;
    end else if (i_flush) begin
      r_valid     <= 1'b0;
      r_has_data  <= 1'b0;
      r_committed <= 1'b0;
    end else if (i_alloc.we) begin
      r_valid     <= 1'b1;
      r_has_data  <= 1'b0;
      r_committed <= 1'b0;
    end else if (o_finish) begin
      r_valid     <= 1'b0;
      r_has_data  <= 1'b0;
      r_committed <= 1'b0;
    end else begin
      if (w_upd_valid) begin
        r_has_data <= 1'b1;
      end
      if (w_commit_hit) begin
        r_committed <= 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (i_alloc.we) begin
      r_tag <= i_alloc.tag;
    end
    if (w_upd_valid) begin
      r_paddr <= w_upd_paddr;
      r_size  <= w_upd_size;
    end
  end

  assign o_entry.valid     = r_valid;
  assign o_entry.tag       = r_tag;
  assign o_entry.has_data  = r_has_data;
  assign o_entry.committed = r_committed;
  assign o_entry.paddr     = r_paddr;
  assign o_entry.size      = r_size;

endmodule

`default_nettype wire

// File: hw/ldq_haz_check.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_haz_check (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire ldq_pkg::ldq_entry_t  i_entries [`LDQ_SIZE],
  input  wire logic [`LDQ_SIZE-1:0] i_out_ptr_oh,
  input  wire ldq_pkg::st_haz_req_t i_haz_req [`LDQ_PIPES],
  output ldq_pkg::st_haz_rsp_t      o_haz_rsp [`LDQ_PIPES]
);

  localparam int IDX_W = $clog2(`LDQ_SIZE);

  logic [IDX_W-1:0] w_out_idx;

  always_comb begin : out_idx_blk
    w_out_idx = '0;
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      if (i_out_ptr_oh[e]) begin
        w_out_idx = IDX_W'(e);
      end
    end
  end

  // ----------------------------------------------------------------------
  // One search per store pipe
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < `LDQ_PIPES; p++) begin : g_pipe
    logic [7:0]           w_st_mask;
    logic [`LDQ_SIZE-1:0] w_haz_vld;
    ldq_pkg::tag_t        w_sel_tag;
    logic                 r_hit;
    ldq_pkg::tag_t        r_tag;

    assign w_st_mask = ldq_pkg::byte_mask(i_haz_req[p].size, i_haz_req[p].paddr[2:0]);

    // Younger load with data in the same 8-byte word, bytes overlapping
    for (genvar e = 0; e < `LDQ_SIZE; e++) begin : g_entry
      assign w_haz_vld[e] =
        i_haz_req[p].valid && i_entries[e].valid && i_entries[e].has_data &&
        ldq_pkg::tag_older(i_haz_req[p].tag, i_entries[e].tag) &&
        (i_haz_req[p].paddr[`LDQ_PADDR_W-1:3] == i_entries[e].paddr[`LDQ_PADDR_W-1:3]) &&
        (|(w_st_mask & ldq_pkg::byte_mask(i_entries[e].size, i_entries[e].paddr[2:0])));
    end

    // Walk from the head, wrapping, and keep the first hit
    always_comb begin : oldest_sel_blk
      logic             found;
      logic [IDX_W-1:0] idx;
      found     = 1'b0;
      w_sel_tag = '0;
      for (int i = 0; i < `LDQ_SIZE; i++) begin
        idx = w_out_idx + IDX_W'(i);
        if (!found && w_haz_vld[idx]) begin
          found     = 1'b1;
          w_sel_tag = i_entries[idx].tag;
        end
      end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_hit <= 1'b0;
      end else begin
        r_hit <= |w_haz_vld;
      end
    end

    always_ff @(posedge i_clk) begin
      r_tag <= w_sel_tag;
    end

    assign o_haz_rsp[p].hit = r_hit;
    assign o_haz_rsp[p].tag = r_tag;
  end

endmodule

`default_nettype wire

// File: hw/ldq_pkg.sv
`default_nettype none

`include "ldq_cfg.svh"

package ldq_pkg;

  typedef logic [`LDQ_TAG_W-1:0] tag_t;

  // Size code 0..3 stands for 1, 2, 4 and 8 bytes
  typedef logic [1:0] ld_size_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } disp_t;

  typedef struct packed {
    logic we;
    tag_t tag;
  } alloc_t;

  // EX2 stage update from a load pipe
  typedef struct packed {
    logic                    valid;
    tag_t                    tag;
    logic [`LDQ_PADDR_W-1:0] paddr;
    ld_size_t                size;
  } ldq_upd_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } commit_t;

  typedef struct packed {
    logic                    valid;
    tag_t                    tag;
    logic                    has_data;
    logic                    committed;
    logic [`LDQ_PADDR_W-1:0] paddr;
    ld_size_t                size;
  } ldq_entry_t;

  typedef struct packed {
    logic                    valid;
    tag_t                    tag;
    logic [`LDQ_PADDR_W-1:0] paddr;
    ld_size_t                size;
  } st_haz_req_t;

  typedef struct packed {
    logic hit;
    tag_t tag;
  } st_haz_rsp_t;

  // ----------------------------------------------------------------------
  // Helpers shared by the queue and the testbench
  // ----------------------------------------------------------------------

  // A is older when B - A wraps into the lower half, excluding zero
  function automatic logic tag_older(input tag_t a, input tag_t b);
    tag_t diff;
    diff = b - a;
    return (diff != '0) && !diff[`LDQ_TAG_W-1];
  endfunction

  function automatic logic [7:0] byte_mask(input ld_size_t size, input logic [2:0] addr_lo);
    logic [7:0] base;
    case (size)
      2'd0:    base = 8'h01;
      2'd1:    base = 8'h03;
      2'd2:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << addr_lo;
  endfunction

endpackage

`default_nettype wire

// File: hw/ldq_ptr_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_ptr_ctrl (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire ldq_pkg::disp_t       i_disp [`LDQ_DISP_W],
  input  wire logic                 i_flush,
  input  wire logic [`LDQ_SIZE-1:0] i_entry_valid,
  input  wire logic [`LDQ_SIZE-1:0] i_finish,
  output ldq_pkg::alloc_t           o_alloc [`LDQ_SIZE],
  output logic [`LDQ_SIZE-1:0]      o_out_ptr_oh,
  output logic                      o_ret_valid,
  output logic [`LDQ_CNT_W-1:0]     o_ret_cnt
);

  logic [`LDQ_SIZE-1:0]  r_in_ptr_oh;
  logic [`LDQ_SIZE-1:0]  r_out_ptr_oh;
  logic [`LDQ_SIZE-1:0]  w_slot_ptr_oh [`LDQ_DISP_W];
  logic [`LDQ_CNT_W-1:0] w_disp_cnt;
  logic [`LDQ_CNT_W-1:0] w_valid_cnt;
  logic                  r_ret_valid;
  logic [`LDQ_CNT_W-1:0] r_ret_cnt;

  // Rotate a one-hot pointer left by n entries
  function automatic logic [`LDQ_SIZE-1:0] rotl(input logic [`LDQ_SIZE-1:0] v,
                                                input logic [`LDQ_CNT_W-1:0] n);
    logic [2*`LDQ_SIZE-1:0] dbl;
    dbl = {v, v} << n;
    return dbl[2*`LDQ_SIZE-1:`LDQ_SIZE];
  endfunction

  always_comb begin : count_blk
    w_disp_cnt  = '0;
    w_valid_cnt = '0;
    for (int k = 0; k < `LDQ_DISP_W; k++) begin
      w_disp_cnt = w_disp_cnt + `LDQ_CNT_W'(i_disp[k].valid);
    end
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      w_valid_cnt = w_valid_cnt + `LDQ_CNT_W'(i_entry_valid[e]);
    end
  end

  // ----------------------------------------------------------------------
  // Slot placement, slot k lands k entries after the in pointer
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < `LDQ_DISP_W; k++) begin : g_slot
    assign w_slot_ptr_oh[k] = rotl(r_in_ptr_oh, `LDQ_CNT_W'(k));
  end

  always_comb begin : alloc_blk
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      o_alloc[e] = '0;
      for (int k = 0; k < `LDQ_DISP_W; k++) begin
        if (i_disp[k].valid && w_slot_ptr_oh[k][e]) begin
          o_alloc[e].we  = 1'b1;
          o_alloc[e].tag = i_disp[k].tag;
        end
      end
    end
  end

  // Only the oldest entry can finish, so the out pointer moves by one
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh  <= `LDQ_SIZE'(1);
      r_out_ptr_oh <= `LDQ_SIZE'(1);
    end else if (i_flush) begin
      r_in_ptr_oh  <= `LDQ_SIZE'(1);
      r_out_ptr_oh <= `LDQ_SIZE'(1);
    end else begin
      r_in_ptr_oh <= rotl(r_in_ptr_oh, w_disp_cnt);
      if (|i_finish) begin
        r_out_ptr_oh <= rotl(r_out_ptr_oh, `LDQ_CNT_W'(1));
      end
    end
  end

  // Credit return, a flush returns everything that was occupied
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ret_valid <= 1'b0;
      r_ret_cnt   <= '0;
    end else if (i_flush) begin
      r_ret_valid <= |i_entry_valid;
      r_ret_cnt   <= w_valid_cnt;
    end else begin
      r_ret_valid <= |i_finish;
      r_ret_cnt   <= (|i_finish) ? `LDQ_CNT_W'(1) : '0;
    end
  end

  assign o_out_ptr_oh = r_out_ptr_oh;
  assign o_ret_valid  = r_ret_valid;
  assign o_ret_cnt    = r_ret_cnt;

endmodule

`default_nettype wire

// File: hw/ldq_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_top (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire ldq_pkg::disp_t        i_disp [`LDQ_DISP_W],
  input  wire ldq_pkg::ldq_upd_t     i_upd [`LDQ_PIPES],
  input  wire ldq_pkg::commit_t      i_commit,
  input  wire logic                  i_flush,
  input  wire ldq_pkg::st_haz_req_t  i_haz_req [`LDQ_PIPES],
  output ldq_pkg::st_haz_rsp_t       o_haz_rsp [`LDQ_PIPES],
  output logic                       o_ret_valid,
  output logic [`LDQ_CNT_W-1:0]      o_ret_cnt
);

  ldq_pkg::alloc_t     w_alloc [`LDQ_SIZE];
  ldq_pkg::ldq_entry_t w_entries [`LDQ_SIZE];
  logic [`LDQ_SIZE-1:0] w_out_ptr_oh;
  logic [`LDQ_SIZE-1:0] w_entry_valid;
  logic [`LDQ_SIZE-1:0] w_finish;

  ldq_ptr_ctrl u_ptr_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp        (i_disp),
    .i_flush       (i_flush),
    .i_entry_valid (w_entry_valid),
    .i_finish      (w_finish),
    .o_alloc       (w_alloc),
    .o_out_ptr_oh  (w_out_ptr_oh),
    .o_ret_valid   (o_ret_valid),
    .o_ret_cnt     (o_ret_cnt)
  );

  // ----------------------------------------------------------------------
  // Queue entries
  // ----------------------------------------------------------------------
  for (genvar e = 0; e < `LDQ_SIZE; e++) begin : g_entry
    ldq_entry u_entry (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_alloc     (w_alloc[e]),
      .i_upd       (i_upd),
      .i_commit    (i_commit),
      .i_flush     (i_flush),
      .i_is_oldest (w_out_ptr_oh[e]),
      .o_entry     (w_entries[e]),
      .o_finish    (w_finish[e])
    );

    assign w_entry_valid[e] = w_entries[e].valid;
  end

  // Store to load hazard search
  ldq_haz_check u_haz_check (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_entries    (w_entries),
    .i_out_ptr_oh (w_out_ptr_oh),
    .i_haz_req    (i_haz_req),
    .o_haz_rsp    (o_haz_rsp)
  );

endmodule

`default_nettype wire

// File: ldq.f
+incdir+hw
hw/ldq_pkg.sv
hw/ldq_ptr_ctrl.sv
hw/ldq_entry.sv
hw/ldq_haz_check.sv
hw/ldq_top.sv
test/ldq_properties.sv
test/ldq_tb.sv

// File: test/ldq_properties.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_properties (
  input wire logic                  i_clk,
  input wire logic                  i_reset_n,
  input wire logic [`LDQ_SIZE-1:0]  i_entry_valid,
  input wire logic [`LDQ_CNT_W-1:0] i_disp_cnt,
  input wire logic [`LDQ_SIZE-1:0]  i_in_ptr_oh,
  input wire logic [`LDQ_SIZE-1:0]  i_out_ptr_oh
);

  // Dispatch stays within the free entries
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ($countones(i_entry_valid) + int'(i_disp_cnt)) <= `LDQ_SIZE)
    else $error("dispatch exceeds free entries");

  // Empty queue means both pointers meet
  a_empty_ptrs: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(|i_entry_valid) |-> (i_in_ptr_oh == i_out_ptr_oh))
    else $error("pointers differ on an empty queue");

endmodule

bind ldq_ptr_ctrl ldq_properties u_props (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_entry_valid (i_entry_valid),
  .i_disp_cnt    (w_disp_cnt),
  .i_in_ptr_oh   (r_in_ptr_oh),
  .i_out_ptr_oh  (r_out_ptr_oh)
);

`default_nettype wire

// File: test/ldq_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "ldq_cfg.svh"

module ldq_tb;

  localparam int N_RAND      = 400;
  localparam int TEST_CYCLES = 8 + N_RAND + 700;
  localparam int TIMEOUT_NS  = TEST_CYCLES * 4 + 2000;

  logic                  i_clk;
  logic                  i_reset_n;
  ldq_pkg::disp_t        i_disp [`LDQ_DISP_W];
  ldq_pkg::ldq_upd_t     i_upd [`LDQ_PIPES];
  ldq_pkg::commit_t      i_commit;
  logic                  i_flush;
  ldq_pkg::st_haz_req_t  i_haz_req [`LDQ_PIPES];
  ldq_pkg::st_haz_rsp_t  o_haz_rsp [`LDQ_PIPES];
  logic                  o_ret_valid;
  logic [`LDQ_CNT_W-1:0] o_ret_cnt;

  // Staged inputs for the next cycle
  ldq_pkg::disp_t        nx_disp [`LDQ_DISP_W];
  ldq_pkg::ldq_upd_t     nx_upd [`LDQ_PIPES];
  ldq_pkg::commit_t      nx_commit;
  logic                  nx_flush;
  ldq_pkg::st_haz_req_t  nx_haz [`LDQ_PIPES];

  // Queue model and expected outputs
  ldq_pkg::ldq_entry_t   m_q [`LDQ_SIZE];
  int                    m_in;
  int                    m_out;
  int                    bus_disp;
  logic                  exp_ret_valid;
  int                    exp_ret_cnt;
  ldq_pkg::st_haz_rsp_t  exp_haz [`LDQ_PIPES];
  int                    ret_pulses;
  int                    last_ret_cnt;
  logic [`LDQ_TAG_W-1:0] next_tag;

  ldq_top u_dut (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_disp      (i_disp),
    .i_upd       (i_upd),
    .i_commit    (i_commit),
    .i_flush     (i_flush),
    .i_haz_req   (i_haz_req),
    .o_haz_rsp   (o_haz_rsp),
    .o_ret_valid (o_ret_valid),
    .o_ret_cnt   (o_ret_cnt)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic ldq_pkg::st_haz_rsp_t ref_haz(input ldq_pkg::st_haz_req_t req);
    ldq_pkg::st_haz_rsp_t rsp;
    int                   idx;
    int                   lo_s;
    int                   lo_l;
    logic [4:0]           d;
    logic                 ovl;
    rsp = '0;
    lo_s = int'(req.paddr[2:0]);
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      idx  = (m_out + i) % `LDQ_SIZE;
      d    = m_q[idx].tag - req.tag;
      lo_l = int'(m_q[idx].paddr[2:0]);
      ovl  = 1'b0;
      // Bytes past the end of the 8-byte word do not count
      for (int b = 0; b < 8; b++) begin
        if (b >= lo_s && b < lo_s + (1 << req.size) &&
            b >= lo_l && b < lo_l + (1 << m_q[idx].size)) begin
          ovl = 1'b1;
        end
      end
      if (req.valid && !rsp.hit && m_q[idx].valid && m_q[idx].has_data &&
          d >= 1 && d <= 15 && ovl &&
          req.paddr[`LDQ_PADDR_W-1:3] == m_q[idx].paddr[`LDQ_PADDR_W-1:3]) begin
        rsp.hit = 1'b1;
        rsp.tag = m_q[idx].tag;
      end
    end
    return rsp;
  endfunction

  task automatic model_step();
    logic fin;
    int   cnt;
    fin = m_q[m_out].valid && m_q[m_out].committed && m_q[m_out].has_data;
    for (int p = 0; p < `LDQ_PIPES; p++) begin
      exp_haz[p] = ref_haz(i_haz_req[p]);
    end
    if (i_flush) begin
      cnt = 0;
      for (int e = 0; e < `LDQ_SIZE; e++) begin
        cnt += int'(m_q[e].valid);
        m_q[e] = '0;
      end
      exp_ret_valid = (cnt != 0);
      exp_ret_cnt   = cnt;
      m_in  = 0;
      m_out = 0;
    end else begin
      exp_ret_valid = fin;
      exp_ret_cnt   = int'(fin);
      for (int e = 0; e < `LDQ_SIZE; e++) begin
        for (int p = 0; p < `LDQ_PIPES; p++) begin
          if (m_q[e].valid && i_upd[p].valid && i_upd[p].tag == m_q[e].tag) begin
            m_q[e].has_data = 1'b1;
            m_q[e].paddr    = i_upd[p].paddr;
            m_q[e].size     = i_upd[p].size;
          end
        end
        if (m_q[e].valid && i_commit.valid && i_commit.tag == m_q[e].tag) begin
          m_q[e].committed = 1'b1;
        end
      end
      if (fin) begin
        m_q[m_out] = '0;
        m_out = (m_out + 1) % `LDQ_SIZE;
      end
      for (int k = 0; k < `LDQ_DISP_W; k++) begin
        if (i_disp[k].valid) begin
          m_q[m_in]       = '0;
          m_q[m_in].valid = 1'b1;
          m_q[m_in].tag   = i_disp[k].tag;
          m_in = (m_in + 1) % `LDQ_SIZE;
        end
      end
    end
  endtask

  // Compare on the falling edge while outputs are stable
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      check_val("o_ret_valid", 32'(o_ret_valid), 32'(exp_ret_valid));
      if (exp_ret_valid) begin
        check_val("o_ret_cnt", 32'(o_ret_cnt), 32'(exp_ret_cnt));
      end
      if (o_ret_valid) begin
        ret_pulses++;
        last_ret_cnt = int'(o_ret_cnt);
      end
      for (int p = 0; p < `LDQ_PIPES; p++) begin
        check_val("o_haz_rsp.hit", 32'(o_haz_rsp[p].hit), 32'(exp_haz[p].hit));
        if (exp_haz[p].hit) begin
          check_val("o_haz_rsp.tag", 32'(o_haz_rsp[p].tag), 32'(exp_haz[p].tag));
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic cycle();
    @(posedge i_clk);
    if (i_reset_n) begin
      model_step();
    end
    bus_disp = 0;
    for (int k = 0; k < `LDQ_DISP_W; k++) begin
      bus_disp += int'(nx_disp[k].valid);
      i_disp[k] <= nx_disp[k];
      nx_disp[k] = '0;
    end
    for (int p = 0; p < `LDQ_PIPES; p++) begin
      i_upd[p]     <= nx_upd[p];
      i_haz_req[p] <= nx_haz[p];
      nx_upd[p] = '0;
      nx_haz[p] = '0;
    end
    i_commit <= nx_commit;
    i_flush  <= nx_flush;
    nx_commit = '0;
    nx_flush  = 1'b0;
  endtask

  // Model occupancy plus loads driven for the coming edge
  function automatic int occupancy();
    int cnt;
    cnt = 0;
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      cnt += int'(m_q[e].valid);
    end
    return cnt + bus_disp;
  endfunction

  task automatic stage_disp(input int n);
    for (int k = 0; k < n; k++) begin
      nx_disp[k].valid = 1'b1;
      nx_disp[k].tag   = next_tag;
      next_tag++;
    end
  endtask

  task automatic stage_upd(input int p, input logic [4:0] tag,
                           input logic [31:0] paddr, input logic [1:0] size);
    nx_upd[p].valid = 1'b1;
    nx_upd[p].tag   = tag;
    nx_upd[p].paddr = paddr;
    nx_upd[p].size  = size;
  endtask

  task automatic wait_ret(input int target);
    int n;
    n = 0;
    while (ret_pulses < target) begin
      cycle();
      n++;
      if (n > 60) begin
        $display("No credit return arrived within 60 cycles");
        $display("Simulation finished: FAIL");
        $fatal(1, "credit return missing");
      end
    end
  endtask

  // Give data and commit to the oldest load until the queue is empty
  task automatic drain();
    int n;
    n = 0;
    while (occupancy() != 0 && n < 80) begin
      if (m_q[m_out].valid && !m_q[m_out].has_data) begin
        stage_upd(0, m_q[m_out].tag, 32'h3000, 2'd3);
      end
      if (m_q[m_out].valid && !m_q[m_out].committed) begin
        nx_commit = '{valid: 1'b1, tag: m_q[m_out].tag};
      end
      cycle();
      n++;
    end
    repeat (3) cycle();
  endtask

  task automatic random_cycle();
    int idx0;
    int idx;
    int n;
    idx0 = -1;
    if ($urandom % 64 == 0) begin
      nx_flush = 1'b1;
    end else begin
      n = $urandom % 3;
      if (n > `LDQ_SIZE - occupancy()) begin
        n = `LDQ_SIZE - occupancy();
      end
      stage_disp(n);
    end
    for (int p = 0; p < `LDQ_PIPES; p++) begin
      idx = $urandom % `LDQ_SIZE;
      if (m_q[idx].valid && !m_q[idx].has_data && idx != idx0) begin
        stage_upd(p, m_q[idx].tag, {29'(32'h400 + $urandom % 2), 3'($urandom)},
                  2'($urandom));
        idx0 = idx;
      end
      if ($urandom % 2 == 0) begin
        nx_haz[p].valid = 1'b1;
        nx_haz[p].tag   = next_tag - 5'd1 - 5'($urandom % 10);
        nx_haz[p].paddr = {29'(32'h400 + $urandom % 2), 3'($urandom)};
        nx_haz[p].size  = 2'($urandom);
      end
    end
    idx = $urandom % `LDQ_SIZE;
    if (m_q[idx].valid && !m_q[idx].committed) begin
      nx_commit = '{valid: 1'b1, tag: m_q[idx].tag};
    end
    cycle();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main_blk
    logic [4:0] base;
    int         p0;
    void'($urandom(32'h2e98));
    i_reset_n = 1'b0;
    i_flush   = 1'b0;
    i_commit  = '0;
    nx_flush  = 1'b0;
    nx_commit = '0;
    for (int k = 0; k < `LDQ_DISP_W; k++) begin
      i_disp[k]  = '0;
      nx_disp[k] = '0;
    end
    for (int p = 0; p < `LDQ_PIPES; p++) begin
      i_upd[p]     = '0;
      i_haz_req[p] = '0;
      nx_upd[p]    = '0;
      nx_haz[p]    = '0;
    end
    for (int e = 0; e < `LDQ_SIZE; e++) begin
      m_q[e] = '0;
    end
    m_in = 0;
    m_out = 0;
    bus_disp = 0;
    exp_ret_valid = 1'b0;
    exp_ret_cnt = 0;
    exp_haz[0] = '0;
    exp_haz[1] = '0;
    ret_pulses = 0;
    last_ret_cnt = 0;
    next_tag = '0;
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    cycle();

    // In-order fill, data, commit and free
    base = next_tag;
    repeat (4) begin
      stage_disp(2);
      cycle();
    end
    for (int i = 0; i < 8; i++) begin
      stage_upd(i % 2, base + 5'(i), 32'h1000 + 32'(8 * i), 2'd3);
      cycle();
    end
    for (int i = 0; i < 8; i++) begin
      nx_commit = '{valid: 1'b1, tag: base + 5'(i)};
      cycle();
    end
    wait_ret(8);
    repeat (4) cycle();
    check_val("ret_pulses", 32'(ret_pulses), 32'd8);

    // Younger commits first and nothing frees until the head commits
    p0 = ret_pulses;
    base = next_tag;
    stage_disp(2);
    cycle();
    stage_disp(2);
    cycle();
    for (int i = 0; i < 4; i++) begin
      stage_upd(0, base + 5'(i), 32'h1100, 2'd2);
      cycle();
    end
    for (int i = 3; i > 0; i--) begin
      nx_commit = '{valid: 1'b1, tag: base + 5'(i)};
      cycle();
    end
    repeat (4) cycle();
    check_val("ret_pulses_early", 32'(ret_pulses), 32'(p0));
    nx_commit = '{valid: 1'b1, tag: base};
    cycle();
    wait_ret(p0 + 4);

    // Flush with five loads and restart from entry 0
    stage_disp(2);
    cycle();
    stage_disp(2);
    cycle();
    stage_disp(1);
    cycle();
    nx_flush = 1'b1;
    cycle();
    wait_ret(ret_pulses + 1);
    check_val("flush_ret_cnt", 32'(last_ret_cnt), 32'd5);
    stage_disp(1);
    cycle();
    cycle();
    #1;
    check_val("entry0_valid", 32'(u_dut.w_entries[0].valid), 32'd1);
    drain();

    for (int c = 0; c < N_RAND; c++) begin
      random_cycle();
    end
    drain();

    // Move the head to entry 6 so four loads wrap around
    while (m_out != 6) begin
      stage_disp(1);
      cycle();
      drain();
    end
    base = next_tag;
    stage_disp(2);
    cycle();
    stage_disp(2);
    cycle();
    for (int i = 0; i < 4; i++) begin
      stage_upd(0, base + 5'(i), 32'h2000, 2'd3);
      cycle();
    end
    nx_haz[0] = '{valid: 1'b1, tag: base - 5'd1, paddr: 32'h2004, size: 2'd0};
    cycle();
    cycle();
    #1;
    check_val("wrap_haz_hit", 32'(o_haz_rsp[0].hit), 32'd1);
    check_val("wrap_haz_tag", 32'(o_haz_rsp[0].tag), 32'(base));
    drain();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
